//--- Makefile
# Verilator build and run for the packet classifier testbench

VERILATOR ?= verilator
TOP       ?= tb_parser
BUILD_DIR ?= build
FLAGS     ?= --assert --timescale 1ns/1ps -Wno-fatal

BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f project.f

run: compile
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/header_classifier.sv
// Header FSM watching the receive stream
// Issues one aggregation / output-queue verdict per packet
`timescale 1ns/1ps
`default_nettype none

module header_classifier (
   input  logic      axis_aclk,
   input  logic      axis_resetn,
   stream_if.monitor rx,
   output logic      verdict_valid,
   output logic      verdict_agg
);
   import parser_pkg::*;

   classify_state_t state;
   classify_state_t state_next;
   beat_count_t     beat_count;
   beat_count_t     beat_count_next;
   logic            beat_ok;
   ether_type_t     ether_type;
   app_code_t       app_code;
   logic            decided;

   assign beat_ok    = rx.tvalid & rx.tready;
   assign ether_type = rx.tdata[ETH_LSB +: 16];
   assign app_code   = rx.tdata[APP_LSB +: 2];

   always_comb begin
      state_next      = state;
      beat_count_next = beat_count;
      decided         = 1'b0;
      verdict_agg     = 1'b0;

      case (state)
         PARSE_HEADER: begin
            if (beat_ok) begin
               if (beat_count == ETH_BEAT) begin
                  if (ether_type == AGG_ETHER_TYPE) begin
                     decided     = 1'b1;
                     verdict_agg = 1'b1;
                  end else if (ether_type != IP_ETHER_TYPE) begin
                     decided = 1'b1;
                  end else if (rx.tlast) begin
                     // IP packet too short to carry an app code
                     decided = 1'b1;
                  end
               end else if (beat_count == APP_BEAT) begin
                  // Only IP packets get this far
                  decided     = 1'b1;
                  verdict_agg = (app_code == AGG_APP_CODE);
               end else if (rx.tlast) begin
                  decided = 1'b1;
               end

               if (decided) begin
                  beat_count_next = '0;
                  if (!rx.tlast) begin
                     state_next = WAIT_TLAST;
                  end
               end else begin
                  beat_count_next = beat_count + 1'b1;
               end
            end
         end

         WAIT_TLAST: begin
            // Rest of the packet is payload, just find its end
            if (beat_ok && rx.tlast) begin
               state_next      = PARSE_HEADER;
               beat_count_next = '0;
            end
         end

         default: begin
            state_next      = PARSE_HEADER;
            beat_count_next = '0;
         end
      endcase

      verdict_valid = decided;
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state      <= PARSE_HEADER;
         beat_count <= '0;
      end else begin
         state      <= state_next;
         beat_count <= beat_count_next;
      end
   end

endmodule

`default_nettype wire

//--- hw/packet_buffer.sv
// Fall-through beat buffer between the receive stream and the steering stage
`timescale 1ns/1ps
`default_nettype none

module packet_buffer (
   input  logic     axis_aclk,
   input  logic     axis_resetn,
   stream_if.sink   rx,
   stream_if.source out
);
   import parser_pkg::*;

   typedef logic [PKT_BUF_AW-1:0] buf_addr_t;
   typedef logic [PKT_BUF_AW:0]   buf_level_t;

   // Beat storage, one entry per accepted beat
   data_t data_mem [PKT_BUF_DEPTH];
   keep_t keep_mem [PKT_BUF_DEPTH];
   user_t user_mem [PKT_BUF_DEPTH];
   logic  last_mem [PKT_BUF_DEPTH];

   buf_addr_t  wr_ptr;
   buf_addr_t  rd_ptr;
   buf_level_t level;
   buf_level_t free_slots;
   logic       push;
   logic       pop;

   assign push = rx.tvalid & rx.tready;
   assign pop  = out.tvalid & out.tready;

   // Hold off the sender before the last couple of slots fill
   assign free_slots = buf_level_t'(PKT_BUF_DEPTH) - level;
   assign rx.tready  = (free_slots >= buf_level_t'(BUF_SLACK));

   always_ff @(posedge axis_aclk) begin
      if (push) begin
         data_mem[wr_ptr] <= rx.tdata;
         keep_mem[wr_ptr] <= rx.tkeep;
         user_mem[wr_ptr] <= rx.tuser;
         last_mem[wr_ptr] <= rx.tlast;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // Head beat shows up the cycle after it was written
   assign out.tvalid = (level != '0);
   assign out.tdata  = data_mem[rd_ptr];
   assign out.tkeep  = keep_mem[rd_ptr];
   assign out.tuser  = user_mem[rd_ptr];
   assign out.tlast  = last_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/packet_counters.sv
// Packet counters for the input, aggregation and output-queue streams
// Sticky wrap flag in the top bit, common clear strobe
`timescale 1ns/1ps
`default_nettype none

module packet_counters (
   input  logic                axis_aclk,
   input  logic                axis_resetn,
   input  logic                counter_clear,
   stream_if.monitor           rx,
   stream_if.monitor           agg,
   stream_if.monitor           oq,
   output parser_pkg::counter_t pkt_in_count,
   output parser_pkg::counter_t pkt_agg_count,
   output parser_pkg::counter_t pkt_oq_count
);
   import parser_pkg::*;

   logic rx_pkt;
   logic agg_pkt;
   logic oq_pkt;

   // Count once per packet, on the tlast transfer
   assign rx_pkt  = rx.tvalid & rx.tready & rx.tlast;
   assign agg_pkt = agg.tvalid & agg.tready & agg.tlast;
   assign oq_pkt  = oq.tvalid & oq.tready & oq.tlast;

   function automatic counter_t bump(counter_t cnt, logic hit);
      counter_t nxt;
      nxt = cnt;
      if (hit) begin
         nxt[30:0] = cnt[30:0] + 31'd1;
         // Low bits wrapping sets the overflow flag for good
         if (&cnt[30:0]) begin
            nxt[31] = 1'b1;
         end
      end
      return nxt;
   endfunction

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn || counter_clear) begin
         pkt_in_count  <= '0;
         pkt_agg_count <= '0;
         pkt_oq_count  <= '0;
      end else begin
         pkt_in_count  <= bump(pkt_in_count, rx_pkt);
         pkt_agg_count <= bump(pkt_agg_count, agg_pkt);
         pkt_oq_count  <= bump(pkt_oq_count, oq_pkt);
      end
   end

endmodule

`default_nettype wire

//--- hw/parser_pkg.sv
// Stream widths, header field positions and match values
// Buffer depths, counter and classifier types
`default_nettype none

package parser_pkg;

   // Beat payload widths
   localparam int DATA_W = 64;
   localparam int KEEP_W = DATA_W / 8;
   localparam int USER_W = 128;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [KEEP_W-1:0] keep_t;
   typedef logic [USER_W-1:0] user_t;

   // Bit 31 is the sticky wrap flag, 30..0 the count
   typedef logic [31:0] counter_t;

   typedef logic [2:0]  beat_count_t;
   typedef logic [15:0] ether_type_t;
   typedef logic [1:0]  app_code_t;

   // EtherType sits at absolute bit 96, app code at 272
   localparam beat_count_t ETH_BEAT = 3'd1;
   localparam int          ETH_LSB  = 32;
   localparam beat_count_t APP_BEAT = 3'd4;
   localparam int          APP_LSB  = 16;

   localparam ether_type_t AGG_ETHER_TYPE = 16'h8888;
   // IPv4 as seen on the wire, bytes swapped
   localparam ether_type_t IP_ETHER_TYPE  = 16'h0008;
   localparam app_code_t   AGG_APP_CODE   = 2'b00;

   localparam int PKT_BUF_DEPTH = 256;
   localparam int PKT_BUF_AW    = 8;
   localparam int BUF_SLACK     = 2;

   typedef enum logic {
      PARSE_HEADER,
      WAIT_TLAST
   } classify_state_t;

endpackage

`default_nettype wire

//--- hw/parser_top.sv
// Classifier top level with plain stream ports
// Buffer, classifier, steering stage and packet counters
`timescale 1ns/1ps
`default_nettype none

module parser_top (
   input  logic                 axis_aclk,
   input  logic                 axis_resetn,
   input  logic                 counter_clear,

   // Receive stream
   input  parser_pkg::data_t    rx_tdata,
   input  parser_pkg::keep_t    rx_tkeep,
   input  parser_pkg::user_t    rx_tuser,
   input  logic                 rx_tvalid,
   output logic                 rx_tready,
   input  logic                 rx_tlast,

   // Aggregation stream
   output parser_pkg::data_t    agg_tdata,
   output parser_pkg::keep_t    agg_tkeep,
   output parser_pkg::user_t    agg_tuser,
   output logic                 agg_tvalid,
   input  logic                 agg_tready,
   output logic                 agg_tlast,

   // Output-queue stream
   output parser_pkg::data_t    oq_tdata,
   output parser_pkg::keep_t    oq_tkeep,
   output parser_pkg::user_t    oq_tuser,
   output logic                 oq_tvalid,
   input  logic                 oq_tready,
   output logic                 oq_tlast,

   output parser_pkg::counter_t pkt_in_count,
   output parser_pkg::counter_t pkt_agg_count,
   output parser_pkg::counter_t pkt_oq_count
);

   logic verdict_valid;
   logic verdict_agg;

   stream_if rx_s ();
   stream_if buf_s ();
   stream_if agg_s ();
   stream_if oq_s ();

   assign rx_s.tdata  = rx_tdata;
   assign rx_s.tkeep  = rx_tkeep;
   assign rx_s.tuser  = rx_tuser;
   assign rx_s.tvalid = rx_tvalid;
   assign rx_s.tlast  = rx_tlast;
   assign rx_tready   = rx_s.tready;

   assign agg_tdata    = agg_s.tdata;
   assign agg_tkeep    = agg_s.tkeep;
   assign agg_tuser    = agg_s.tuser;
   assign agg_tvalid   = agg_s.tvalid;
   assign agg_tlast    = agg_s.tlast;
   assign agg_s.tready = agg_tready;

   assign oq_tdata    = oq_s.tdata;
   assign oq_tkeep    = oq_s.tkeep;
   assign oq_tuser    = oq_s.tuser;
   assign oq_tvalid   = oq_s.tvalid;
   assign oq_tlast    = oq_s.tlast;
   assign oq_s.tready = oq_tready;

   packet_buffer i_packet_buffer (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .rx          (rx_s.sink),
      .out         (buf_s.source)
   );

   // Sees the same beats the buffer accepts
   header_classifier i_header_classifier (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .rx            (rx_s.monitor),
      .verdict_valid (verdict_valid),
      .verdict_agg   (verdict_agg)
   );

   route_steer i_route_steer (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .verdict_valid (verdict_valid),
      .verdict_agg   (verdict_agg),
      .in            (buf_s.sink),
      .agg           (agg_s.source),
      .oq            (oq_s.source)
   );

   packet_counters i_packet_counters (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .counter_clear (counter_clear),
      .rx            (rx_s.monitor),
      .agg           (agg_s.monitor),
      .oq            (oq_s.monitor),
      .pkt_in_count  (pkt_in_count),
      .pkt_agg_count (pkt_agg_count),
      .pkt_oq_count  (pkt_oq_count)
   );

endmodule

`default_nettype wire

//--- hw/route_steer.sv
// Verdict queue and steering of buffered beats
// to the aggregation or output-queue stream
`timescale 1ns/1ps
`default_nettype none

module route_steer (
   input  logic     axis_aclk,
   input  logic     axis_resetn,
   input  logic     verdict_valid,
   input  logic     verdict_agg,
   stream_if.sink   in,
   stream_if.source agg,
   stream_if.source oq
);
   import parser_pkg::*;

   typedef logic [PKT_BUF_AW-1:0] vq_addr_t;
   typedef logic [PKT_BUF_AW:0]   vq_level_t;

   // One bit per packet, set means aggregation
   logic      vq_mem [PKT_BUF_DEPTH];
   vq_addr_t  vq_wr_ptr;
   vq_addr_t  vq_rd_ptr;
   vq_level_t vq_level;
   logic      head_valid;
   logic      head_agg;
   logic      beat_done;
   logic      pkt_done;

   assign head_valid = (vq_level != '0);
   assign head_agg   = vq_mem[vq_rd_ptr];

   // Beat waits until its packet has a verdict
   assign agg.tvalid = in.tvalid & head_valid & head_agg;
   assign oq.tvalid  = in.tvalid & head_valid & ~head_agg;
   assign in.tready  = head_valid & (head_agg ? agg.tready : oq.tready);

   assign agg.tdata = in.tdata;
   assign agg.tkeep = in.tkeep;
   assign agg.tuser = in.tuser;
   assign agg.tlast = in.tlast;
   assign oq.tdata  = in.tdata;
   assign oq.tkeep  = in.tkeep;
   assign oq.tuser  = in.tuser;
   assign oq.tlast  = in.tlast;

   assign beat_done = in.tvalid & in.tready;
   assign pkt_done  = beat_done & in.tlast;

   always_ff @(posedge axis_aclk) begin
      if (verdict_valid) begin
         vq_mem[vq_wr_ptr] <= verdict_agg;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         vq_wr_ptr <= '0;
         vq_rd_ptr <= '0;
         vq_level  <= '0;
      end else begin
         if (verdict_valid) begin
            vq_wr_ptr <= vq_wr_ptr + 1'b1;
         end
         // Verdict retires with the packet's last beat
         if (pkt_done) begin
            vq_rd_ptr <= vq_rd_ptr + 1'b1;
         end
         case ({verdict_valid, pkt_done})
            2'b10:   vq_level <= vq_level + 1'b1;
            2'b01:   vq_level <= vq_level - 1'b1;
            default: vq_level <= vq_level;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/stream_if.sv
// AXI-Stream bundle with source, sink and monitor views
`timescale 1ns/1ps
`default_nettype none

interface stream_if;
   import parser_pkg::*;

   data_t tdata;
   keep_t tkeep;
   user_t tuser;
   logic  tvalid;
   logic  tready;
   logic  tlast;

   modport source (
      output tdata, tkeep, tuser, tvalid, tlast,
      input  tready
   );

   modport sink (
      input  tdata, tkeep, tuser, tvalid, tlast,
      output tready
   );

   // Passive observer, drives nothing
   modport monitor (
      input tdata, tkeep, tuser, tvalid, tready, tlast
   );

endinterface

`default_nettype wire

//--- project.f
hw/parser_pkg.sv
hw/stream_if.sv
hw/packet_buffer.sv
hw/header_classifier.sv
hw/route_steer.sv
hw/packet_counters.sv
hw/parser_top.sv
sim/tb_parser.sv

//--- sim/tb_parser.sv
// Testbench for the packet classifier
// Packet generator, routing model and checks on both output streams
`timescale 1ns/1ps
`default_nettype none

module tb_parser;
   import parser_pkg::*;

   // One beat as {data, keep, user, last}
   typedef logic [DATA_W+KEEP_W+USER_W:0] beat_t;

   localparam int DRAIN_LIMIT = 5000;

   logic     axis_aclk;
   logic     axis_resetn;
   logic     counter_clear;
   data_t    rx_tdata;
   keep_t    rx_tkeep;
   user_t    rx_tuser;
   logic     rx_tvalid;
   logic     rx_tready;
   logic     rx_tlast;
   data_t    agg_tdata;
   keep_t    agg_tkeep;
   user_t    agg_tuser;
   logic     agg_tvalid;
   logic     agg_tready;
   logic     agg_tlast;
   data_t    oq_tdata;
   keep_t    oq_tkeep;
   user_t    oq_tuser;
   logic     oq_tvalid;
   logic     oq_tready;
   logic     oq_tlast;
   counter_t pkt_in_count;
   counter_t pkt_agg_count;
   counter_t pkt_oq_count;

   integer seed;
   beat_t  tx_q[$];
   beat_t  exp_agg[$];
   beat_t  exp_oq[$];
   beat_t  next_beat;
   beat_t  agg_head;
   beat_t  oq_head;
   bit     agg_have;
   bit     oq_have;
   bit     hung;
   int     errors;
   int     err_mark;
   int     tests_run;
   int     tests_failed;
   int     sent_total;
   int     sent_agg;
   int     sent_oq;

   parser_top i_parser_top (.*);

   initial begin
      axis_aclk = 1'b0;
      forever #50 axis_aclk = ~axis_aclk;
   end

   // Expected port from the EtherType on beat 1 and the app code on beat 4
   function automatic bit goes_agg(logic [15:0] eth, logic [1:0] app, int len);
      if (len <= int'(ETH_BEAT)) return 1'b0;
      if (eth == AGG_ETHER_TYPE) return 1'b1;
      if (eth != IP_ETHER_TYPE) return 1'b0;
      if (len <= int'(APP_BEAT)) return 1'b0;
      return app == AGG_APP_CODE;
   endfunction

   function automatic bit in_flight();
      return tx_q.size() != 0 || rx_tvalid || exp_agg.size() != 0 || exp_oq.size() != 0;
   endfunction

   task automatic check_beat(input string port, input beat_t got, input bit have_exp,
                             input beat_t exp);
      assert (have_exp) else begin
         errors++;
         $display("FAIL %0t: beat on %s where no packet was expected", $time, port);
      end
      assert (!have_exp || got == exp) else begin
         errors++;
         $display("FAIL %0t: %s beat %h, expected %h", $time, port, got, exp);
      end
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp) else begin
         errors++;
         $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // Misplace puts the EtherType on beat 0 and IP on beat 1
   task automatic send_packet(input logic [15:0] eth, input logic [1:0] app, input int len,
                              input bit misplace);
      data_t       d;
      keep_t       k;
      user_t       u;
      logic [15:0] eth_seen;
      logic [1:0]  app_seen;
      beat_t       pkt[$];
      eth_seen = '0;
      app_seen = '0;
      for (int i = 0; i < len; i++) begin
         d = {$random(seed), $random(seed)};
         k = (i == len - 1) ? (keep_t'($random(seed)) | keep_t'(1)) : '1;
         u = {$random(seed), $random(seed), $random(seed), $random(seed)};
         if (misplace && i == 0) d[ETH_LSB +: 16] = eth;
         if (i == int'(ETH_BEAT)) d[ETH_LSB +: 16] = misplace ? IP_ETHER_TYPE : eth;
         if (i == int'(APP_BEAT)) d[APP_LSB +: 2] = app;
         if (i == int'(ETH_BEAT)) eth_seen = d[ETH_LSB +: 16];
         if (i == int'(APP_BEAT)) app_seen = d[APP_LSB +: 2];
         pkt.push_back({d, k, u, i == len - 1});
      end
      sent_total++;
      if (goes_agg(eth_seen, app_seen, len)) sent_agg++;
      else sent_oq++;
      foreach (pkt[i]) begin
         tx_q.push_back(pkt[i]);
         if (goes_agg(eth_seen, app_seen, len)) exp_agg.push_back(pkt[i]);
         else exp_oq.push_back(pkt[i]);
      end
   endtask

   task automatic send_random(input int count);
      int          kind;
      logic [15:0] eth;
      for (int n = 0; n < count; n++) begin
         kind = {$random(seed)} % 3;
         case (kind)
            0:       eth = AGG_ETHER_TYPE;
            1:       eth = IP_ETHER_TYPE;
            default: eth = 16'($random(seed));
         endcase
         send_packet(eth, 2'($random(seed)), 1 + {$random(seed)} % 9, 1'b0);
      end
   endtask

   // Let all queued packets through, optionally with random back-pressure
   task automatic wait_drain(input string what, input bit toggle);
      int cycles;
      cycles = 0;
      while (!hung && in_flight()) begin
         @(posedge axis_aclk);
         if (toggle) begin
            agg_tready <= 1'($random(seed));
            oq_tready  <= 1'($random(seed));
         end
         @(negedge axis_aclk);
         cycles++;
         if (cycles >= DRAIN_LIMIT) begin
            hung = 1'b1;
            errors++;
            $display("Timeout: packets of test %s did not drain within %0d cycles",
                     what, DRAIN_LIMIT);
         end
      end
      if (toggle) begin
         // Both outputs open again for the tests that follow
         @(posedge axis_aclk);
         agg_tready <= 1'b1;
         oq_tready  <= 1'b1;
         @(negedge axis_aclk);
      end
   endtask

   task automatic end_test(input string name, input bit toggle);
      wait_drain(name, toggle);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // Feed queued beats, holding each until accepted
   always @(posedge axis_aclk) begin
      if (axis_resetn && (!rx_tvalid || rx_tready)) begin
         if (tx_q.size() != 0) begin
            next_beat = tx_q.pop_front();
            {rx_tdata, rx_tkeep, rx_tuser, rx_tlast} <= next_beat;
            rx_tvalid <= 1'b1;
         end else begin
            rx_tvalid <= 1'b0;
         end
      end
   end

   always @(posedge axis_aclk) begin
      if (axis_resetn && agg_tvalid && agg_tready) begin
         agg_have = exp_agg.size() != 0;
         agg_head = agg_have ? exp_agg.pop_front() : '0;
         check_beat("agg", {agg_tdata, agg_tkeep, agg_tuser, agg_tlast}, agg_have, agg_head);
      end
      if (axis_resetn && oq_tvalid && oq_tready) begin
         oq_have = exp_oq.size() != 0;
         oq_head = oq_have ? exp_oq.pop_front() : '0;
         check_beat("oq", {oq_tdata, oq_tkeep, oq_tuser, oq_tlast}, oq_have, oq_head);
      end
   end

   initial begin
      seed          = 80;
      hung          = 1'b0;
      errors        = 0;
      err_mark      = 0;
      tests_run     = 0;
      tests_failed  = 0;
      sent_total    = 0;
      sent_agg      = 0;
      sent_oq       = 0;
      axis_resetn   = 1'b0;
      counter_clear = 1'b0;
      rx_tdata      = '0;
      rx_tkeep      = '0;
      rx_tuser      = '0;
      rx_tvalid     = 1'b0;
      rx_tlast      = 1'b0;
      agg_tready    = 1'b1;
      oq_tready     = 1'b1;
      repeat (8) @(posedge axis_aclk);
      axis_resetn <= 1'b1;
      @(negedge axis_aclk);

      check_value("agg_tvalid after reset", 32'(agg_tvalid), 0);
      check_value("oq_tvalid after reset", 32'(oq_tvalid), 0);
      check_value("rx_tready after reset", 32'(rx_tready), 1);
      check_value("pkt_in_count after reset", pkt_in_count, 0);
      check_value("pkt_agg_count after reset", pkt_agg_count, 0);
      check_value("pkt_oq_count after reset", pkt_oq_count, 0);
      end_test("reset", 1'b0);

      send_packet(AGG_ETHER_TYPE, 2'b11, 3, 1'b0);
      end_test("agg_ethertype", 1'b0);

      // ARP as it appears on the wire
      send_packet(16'h0608, AGG_APP_CODE, 4, 1'b0);
      end_test("other_ethertype", 1'b0);

      send_packet(IP_ETHER_TYPE, AGG_APP_CODE, 6, 1'b0);
      send_packet(IP_ETHER_TYPE, 2'b01, 5, 1'b0);
      send_packet(IP_ETHER_TYPE, 2'b10, 9, 1'b0);
      end_test("ip_app_code", 1'b0);

      send_packet(AGG_ETHER_TYPE, AGG_APP_CODE, 1, 1'b0);
      send_packet(AGG_ETHER_TYPE, AGG_APP_CODE, 2, 1'b1);
      send_packet(IP_ETHER_TYPE, AGG_APP_CODE, 4, 1'b0);
      end_test("short_packets", 1'b0);

      send_random(40);
      end_test("random_traffic", 1'b1);

      check_value("pkt_in_count", pkt_in_count, sent_total);
      check_value("pkt_agg_count", pkt_agg_count, sent_agg);
      check_value("pkt_oq_count", pkt_oq_count, sent_oq);
      @(posedge axis_aclk);
      counter_clear <= 1'b1;
      @(posedge axis_aclk);
      counter_clear <= 1'b0;
      @(negedge axis_aclk);
      check_value("pkt_in_count after clear", pkt_in_count, 0);
      check_value("pkt_agg_count after clear", pkt_agg_count, 0);
      check_value("pkt_oq_count after clear", pkt_oq_count, 0);
      end_test("counters", 1'b0);

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
